// ==== mem_subsys.f ====
+incdir+src
src/mem_pkg.sv
src/bus_arbiter.sv
src/segment_map.sv
src/sram_ctrl.sv
src/sram_array.sv
src/mem_subsys.sv
tb/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mem_subsys \
	-f mem_subsys.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "PASS"
exit 0

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ns
`include "mem_config.svh"

module bus_arbiter (
	input logic clk,
	input logic rst,
	input mem_pkg::bus_req_t req_cpu,
	input mem_pkg::bus_req_t req_chan,
	output mem_pkg::bus_rsp_t rsp_cpu,
	output mem_pkg::bus_rsp_t rsp_chan,
	output mem_pkg::bus_req_t mem_req,
	input mem_pkg::bus_rsp_t mem_rsp
);

	localparam int TMR_BITS = $clog2(`MEM_BUS_TIMEOUT + 1);

	mem_pkg::arb_state_t state;
	logic gnt_chan; // Owner of the bus, 0 = processor
	logic last_chan; // Owner of the previous cycle
	logic [TMR_BITS-1:0] timer;
	logic alarm_q;
	logic ask_cpu;
	logic ask_chan;
	logic held;

	assign ask_cpu = req_cpu.rd | req_cpu.wr | req_cpu.cfg;
	assign ask_chan = req_chan.rd | req_chan.wr | req_chan.cfg;
	assign held = gnt_chan ? ask_chan : ask_cpu; // Granted strobe still up

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::ARB_IDLE;
			gnt_chan <= 1'b0;
			last_chan <= 1'b1; // Processor wins the first tie
			timer <= '0;
			alarm_q <= 1'b0;
		end else begin
			alarm_q <= 1'b0;
			case (state)
				mem_pkg::ARB_IDLE: begin
					if (ask_cpu || ask_chan) begin
						// On a tie the port not served last wins
						gnt_chan <= ask_chan && (!ask_cpu || !last_chan);
						timer <= TMR_BITS'(`MEM_BUS_TIMEOUT - 1);
						state <= mem_pkg::ARB_BUSY;
					end
				end
				mem_pkg::ARB_BUSY: begin
					if (!held) begin
						last_chan <= gnt_chan;
						state <= mem_pkg::ARB_IDLE;
					end else if (!mem_rsp.ok) begin
						if (timer == '0) begin
							alarm_q <= 1'b1; // Nobody answered
							state <= mem_pkg::ARB_RELEASE;
						end else begin
							timer <= timer - 1'b1;
						end
					end
				end
				mem_pkg::ARB_RELEASE: begin
					last_chan <= gnt_chan; // Requester drops its strobe now
					state <= mem_pkg::ARB_IDLE;
				end
				default: state <= mem_pkg::ARB_IDLE;
			endcase
		end
	end

	assign mem_req = (state == mem_pkg::ARB_BUSY) ? (gnt_chan ? req_chan : req_cpu) : '0;

	// Answer goes to the owner only
	always_comb begin
		rsp_cpu = '0;
		rsp_chan = '0;
		if (state == mem_pkg::ARB_BUSY) begin
			if (gnt_chan)
				rsp_chan = mem_rsp;
			else
				rsp_cpu = mem_rsp;
		end
		if (alarm_q) begin
			if (gnt_chan)
				rsp_chan.alarm = 1'b1;
			else
				rsp_cpu.alarm = 1'b1;
		end
	end

	// The controller only answers while a port owns the bus
	a_ok_granted: assert property (@(posedge clk) disable iff (rst)
		mem_rsp.ok |-> state == mem_pkg::ARB_BUSY);

endmodule

// ==== src/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Physical memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Word offset inside one 4K segment
`define MEM_OFS_BITS 12

// Physical segment bits in use, 64 segments of 4K words
`define MEM_PHY_BITS 6

// SRAM word address = physical segment + offset
`define MEM_ADDR_BITS (`MEM_OFS_BITS + `MEM_PHY_BITS)

// Logical segments, 16 blocks of 16 segments
`define MEM_MAP_ENTRIES 256

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MEM_BUS_TIMEOUT 32 // Cycles without ok before alarm

`endif

// ==== src/mem_pkg.sv ====
`include "mem_config.svh"

package mem_pkg;

	typedef logic [15:0] word_t; // Bus data word
	typedef logic [15:0] addr_t; // Bus word address
	typedef logic [3:0] block_t; // Block number sent with every cycle
	typedef logic [7:0] seg_t; // Logical or physical segment
	typedef logic [`MEM_ADDR_BITS-1:0] sram_addr_t;

	// One bus cycle as driven by a requester
	typedef struct packed {
		logic rd;
		logic wr;
		logic cfg; // Memory configuration command
		block_t blk;
		addr_t ad;
		word_t dt;
	} bus_req_t;

	// Answer back to the requester
	typedef struct packed {
		logic ok; // Level, held until the strobe falls
		logic alarm; // Single cycle, no answer from memory
		word_t dt;
	} bus_rsp_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		ACC_IDLE, ACC_MAP, ACC_READ, ACC_WRITE, ACC_OK
	} acc_state_t;

	typedef enum logic [1:0] {CFG_IDLE, CFG_WRITE, CFG_OK} cfg_state_t;

	typedef enum logic [1:0] {ARB_IDLE, ARB_BUSY, ARB_RELEASE} arb_state_t;

endpackage

// ==== src/mem_subsys.sv ====
`timescale 1ns/1ns
`include "mem_config.svh"

module mem_subsys (
	input logic clk,
	input logic rst,
	input mem_pkg::bus_req_t req_cpu,
	input mem_pkg::bus_req_t req_chan,
	output mem_pkg::bus_rsp_t rsp_cpu,
	output mem_pkg::bus_rsp_t rsp_chan
);

	// Granted bus cycle
	mem_pkg::bus_req_t mem_req;
	mem_pkg::bus_rsp_t mem_rsp;

	// Segment map
	logic map_wr_en;
	mem_pkg::seg_t map_wr_seg;
	mem_pkg::seg_t map_wr_phy;
	mem_pkg::seg_t map_rd_seg;
	mem_pkg::seg_t map_rd_phy;

	// SRAM
	mem_pkg::sram_addr_t sram_addr;
	logic sram_we;
	mem_pkg::word_t sram_wdata;
	mem_pkg::word_t sram_rdata;

	bus_arbiter i_arb (
		.clk(clk),
		.rst(rst),
		.req_cpu(req_cpu),
		.req_chan(req_chan),
		.rsp_cpu(rsp_cpu),
		.rsp_chan(rsp_chan),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	sram_ctrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.req(mem_req),
		.rsp(mem_rsp),
		.map_wr_en(map_wr_en),
		.map_wr_seg(map_wr_seg),
		.map_wr_phy(map_wr_phy),
		.map_rd_seg(map_rd_seg),
		.map_rd_phy(map_rd_phy),
		.sram_addr(sram_addr),
		.sram_we(sram_we),
		.sram_wdata(sram_wdata),
		.sram_rdata(sram_rdata)
	);

	segment_map i_map (
		.clk(clk),
		.rst(rst),
		.wr_en(map_wr_en),
		.wr_seg(map_wr_seg),
		.wr_phy(map_wr_phy),
		.rd_seg(map_rd_seg),
		.rd_phy(map_rd_phy)
	);

	sram_array i_sram (
		.clk(clk),
		.addr(sram_addr),
		.we(sram_we),
		.wdata(sram_wdata),
		.rdata(sram_rdata)
	);

endmodule

// ==== src/segment_map.sv ====
`timescale 1ns/1ns
`include "mem_config.svh"

module segment_map (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input mem_pkg::seg_t wr_seg,
	input mem_pkg::seg_t wr_phy,
	input mem_pkg::seg_t rd_seg,
	output mem_pkg::seg_t rd_phy
);

	localparam int ENTRIES = `MEM_MAP_ENTRIES;

	mem_pkg::seg_t map_mem [ENTRIES];
	mem_pkg::seg_t sweep_idx;
	logic sweeping;
	logic [ENTRIES-1:0] cfg_seen; // Configured while the sweep runs
	logic wr_ok;
	logic sweep_we;
	logic mem_we;
	mem_pkg::seg_t mem_wa;
	mem_pkg::seg_t mem_wd;
	mem_pkg::seg_t rd_q;
	mem_pkg::seg_t rd_init_q;
	logic rd_swept_q;

	// Segments 0 and 1 of block 0 are fixed
	assign wr_ok = wr_en && (wr_seg > 8'd1);

	// Sweep yields to configure writes and skips entries they already set
	assign sweep_we = sweeping && !wr_ok && !cfg_seen[sweep_idx];
	assign mem_we = wr_ok | sweep_we;
	assign mem_wa = wr_ok ? wr_seg : sweep_idx;
	assign mem_wd = wr_ok ? wr_phy : ((sweep_idx == 8'd1) ? 8'd1 : 8'd0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reset sweep, one entry per cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			sweeping <= 1'b1;
			sweep_idx <= '0;
			cfg_seen <= '0;
		end else begin
			if (wr_ok)
				cfg_seen[wr_seg] <= 1'b1;
			if (sweeping && !wr_ok) begin
				sweep_idx <= sweep_idx + 8'd1;
				if (sweep_idx == 8'hff)
					sweeping <= 1'b0; // Whole map cleared
			end
		end
	end

	// Map storage and registered lookup
	always_ff @(posedge clk) begin
		if (mem_we)
			map_mem[mem_wa] <= mem_wd;
		rd_q <= map_mem[rd_seg];
		rd_swept_q <= !sweeping || (rd_seg < sweep_idx) || cfg_seen[rd_seg];
		rd_init_q <= (rd_seg < 8'd2) ? rd_seg : 8'd0; // Value after reset
	end

	// Entries the sweep has not reached yet read as their reset value
	assign rd_phy = rd_swept_q ? rd_q : rd_init_q;

	// Fixed entries keep identity mapping once reloaded
	a_fixed_entries: assert property (@(posedge clk) disable iff (rst)
		(!sweeping || sweep_idx > 8'd1) |-> (map_mem[0] == 8'd0 && map_mem[1] == 8'd1));

endmodule

// ==== src/sram_array.sv ====
`timescale 1ns/1ns
`include "mem_config.svh"

// On-chip stand-in for the external SRAM chip
module sram_array (
	input logic clk,
	input mem_pkg::sram_addr_t addr,
	input logic we,
	input mem_pkg::word_t wdata,
	output mem_pkg::word_t rdata
);

	localparam int DEPTH = 1 << `MEM_ADDR_BITS;

	mem_pkg::word_t mem [DEPTH];

	// Single port, read returns the old word on a write cycle
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr]; // Registered read
	end

endmodule

// ==== src/sram_ctrl.sv ====
`timescale 1ns/1ns
`include "mem_config.svh"

module sram_ctrl (
	input logic clk,
	input logic rst,
	input mem_pkg::bus_req_t req,
	output mem_pkg::bus_rsp_t rsp,
	output logic map_wr_en,
	output mem_pkg::seg_t map_wr_seg,
	output mem_pkg::seg_t map_wr_phy,
	output mem_pkg::seg_t map_rd_seg,
	input mem_pkg::seg_t map_rd_phy,
	output mem_pkg::sram_addr_t sram_addr,
	output logic sram_we,
	output mem_pkg::word_t sram_wdata,
	input mem_pkg::word_t sram_rdata
);

	mem_pkg::acc_state_t acc_state;
	mem_pkg::cfg_state_t cfg_state;
	logic acc_ok;
	logic cfg_ok;
	logic unmapped;
	logic cfg_valid;
	mem_pkg::word_t rd_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address translation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Logical segment = block number + top address nibble
	assign map_rd_seg = {req.blk, req.ad[15:`MEM_OFS_BITS]};
	assign unmapped = (map_rd_seg > 8'd1) && (map_rd_phy == '0);

	// Map output is registered, so the address settles during ACC_MAP
	assign sram_addr = {map_rd_phy[`MEM_PHY_BITS-1:0], req.ad[`MEM_OFS_BITS-1:0]};
	assign sram_we = (acc_state == mem_pkg::ACC_WRITE);
	assign sram_wdata = req.dt;

	// Configure takes block from dt[3:0] and segment from dt[15:12], physical from ad[8:1]
	assign cfg_valid = req.cfg && req.ad[0];
	assign map_wr_seg = {req.dt[3:0], req.dt[15:12]};
	assign map_wr_phy = req.ad[8:1];
	assign map_wr_en = (cfg_state == mem_pkg::CFG_WRITE);

	assign rsp = '{ok: acc_ok | cfg_ok, alarm: 1'b0, dt: rd_data};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Access FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_state <= mem_pkg::ACC_IDLE;
			acc_ok <= 1'b0;
		end else begin
			case (acc_state)
				mem_pkg::ACC_IDLE: begin
					if (req.rd || req.wr)
						acc_state <= mem_pkg::ACC_MAP;
				end
				mem_pkg::ACC_MAP: begin
					if (unmapped)
						acc_state <= mem_pkg::ACC_IDLE; // No answer so the bus times out
					else if (req.rd)
						acc_state <= mem_pkg::ACC_READ;
					else if (req.wr)
						acc_state <= mem_pkg::ACC_WRITE;
					else
						acc_state <= mem_pkg::ACC_IDLE;
				end
				mem_pkg::ACC_READ: begin
					acc_ok <= 1'b1;
					acc_state <= mem_pkg::ACC_OK;
				end
				mem_pkg::ACC_WRITE: begin
					acc_ok <= 1'b1;
					acc_state <= mem_pkg::ACC_OK;
				end
				mem_pkg::ACC_OK: begin
					// Hold ok until the requester lets go
					if (!req.rd && !req.wr) begin
						acc_ok <= 1'b0;
						acc_state <= mem_pkg::ACC_IDLE;
					end
				end
				default: acc_state <= mem_pkg::ACC_IDLE;
			endcase
		end
	end

	// Read word arrives from the array during ACC_READ
	always_ff @(posedge clk) begin
		if (acc_state == mem_pkg::ACC_READ)
			rd_data <= sram_rdata;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Configure FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_state <= mem_pkg::CFG_IDLE;
			cfg_ok <= 1'b0;
		end else begin
			case (cfg_state)
				mem_pkg::CFG_IDLE: begin
					if (cfg_valid)
						cfg_state <= mem_pkg::CFG_WRITE;
				end
				mem_pkg::CFG_WRITE: begin
					cfg_ok <= 1'b1; // Map write lands on this edge
					cfg_state <= mem_pkg::CFG_OK;
				end
				mem_pkg::CFG_OK: begin
					if (!req.cfg) begin
						cfg_ok <= 1'b0;
						cfg_state <= mem_pkg::CFG_IDLE;
					end
				end
				default: cfg_state <= mem_pkg::CFG_IDLE;
			endcase
		end
	end

	// SRAM writes only for a held write strobe to a mapped segment
	a_we_in_write: assert property (@(posedge clk) disable iff (rst)
		sram_we |-> req.wr && !unmapped);

endmodule

// ==== tb/mem_trace.txt ====
# port(0 cpu, 1 chan) cmd(R W C, P = read paired with next P) blk addr data result rdata
# configure: data = segment in [15:12] and block in [3:0], addr = physical segment * 2 + 1
# fixed segments 0 and 1 of block 0
0 W 0 0010 1234 OK 0000
1 W 0 1020 5678 OK 0000
0 R 0 0010 0000 OK 1234
1 R 0 1020 0000 OK 5678
# map block 2 seg 3 to physical 0x10, write and read back
0 C 0 0021 3002 OK 0000
0 W 2 3456 beef OK 0000
1 R 2 3456 0000 OK beef
# second logical segment, block 5 seg 7, on the same physical segment
1 C 0 0021 7005 OK 0000
0 R 5 7456 0000 OK beef
# protected entries answer ok and keep their mapping
0 C 0 000b 1000 OK 0000
0 R 0 1020 0000 OK 5678
1 C 0 000b 0000 OK 0000
1 R 0 0010 0000 OK 1234
# unmapped segment times out, then the port works again
1 R 0 5000 0000 ALARM 0000
1 R 0 1020 0000 OK 5678
# configure with address bit 0 clear gets no answer
0 C 0 0020 3002 ALARM 0000
0 R 2 3456 0000 OK beef
# data for the shared cycles
0 W 2 3100 1111 OK 0000
1 C 0 0045 0003 OK 0000
1 W 3 0abc cafe OK 0000
# both ports at once
0 P 2 3100 0000 OK 1111
1 P 3 0abc 0000 OK cafe
0 P 0 0010 0000 OK 1234
1 P 0 1020 0000 OK 5678

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`include "mem_config.svh"

module tb_mem_subsys;

	// One bus cycle from the trace
	typedef struct packed {
		logic port; // 0 = processor, 1 = I/O channel
		logic [7:0] cmd;
		mem_pkg::block_t blk;
		mem_pkg::addr_t ad;
		mem_pkg::word_t dt;
		logic alarm; // Expected to end in alarm
		mem_pkg::word_t rdata;
	} step_t;

	logic clk;
	logic rst;
	mem_pkg::bus_req_t req_cpu;
	mem_pkg::bus_req_t req_chan;
	mem_pkg::bus_rsp_t rsp_cpu;
	mem_pkg::bus_rsp_t rsp_chan;
	step_t steps [$];
	logic loaded;

	mem_subsys i_dut (
		.clk(clk),
		.rst(rst),
		.req_cpu(req_cpu),
		.req_chan(req_chan),
		.rsp_cpu(rsp_cpu),
		.rsp_chan(rsp_chan)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input mem_pkg::word_t got, input mem_pkg::word_t exp,
		input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic load_trace();
		int fd;
		int n;
		int port;
		string line;
		logic [63:0] cmd_txt;
		logic [63:0] res_txt;
		logic [15:0] blk;
		logic [15:0] ad;
		logic [15:0] dt;
		logic [15:0] rdata;
		step_t s;
		fd = $fopen("tb/mem_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file tb/mem_trace.txt");
			$display("tests failed");
			$fatal(1, "Missing trace");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%d %s %h %h %h %s %h",
					port, cmd_txt, blk, ad, dt, res_txt, rdata);
				if (n == 7) begin // Comment and blank lines fail the scan
					s.port = port[0];
					s.cmd = cmd_txt[7:0];
					s.blk = blk[3:0];
					s.ad = ad;
					s.dt = dt;
					s.alarm = (res_txt == "ALARM");
					s.rdata = rdata;
					steps.push_back(s);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive(input logic port, input mem_pkg::bus_req_t r);
		if (port)
			req_chan <= r;
		else
			req_cpu <= r;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One complete bus cycle on one port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_cycle(input step_t s, input int idx);
		mem_pkg::bus_req_t r;
		mem_pkg::bus_rsp_t rsp;
		logic seen_ok;
		logic seen_alarm;
		string tag;
		tag = $sformatf("step %0d port %0d", idx, s.port);
		r = '0;
		r.rd = (s.cmd == "R") || (s.cmd == "P");
		r.wr = (s.cmd == "W");
		r.cfg = (s.cmd == "C");
		r.blk = s.blk;
		r.ad = s.ad;
		r.dt = s.dt;
		@(posedge clk);
		drive(s.port, r); // Strobe held until ok or alarm
		seen_ok = 1'b0;
		seen_alarm = 1'b0;
		while (!seen_ok && !seen_alarm) begin
			@(negedge clk);
			rsp = s.port ? rsp_chan : rsp_cpu;
			seen_ok = rsp.ok;
			seen_alarm = rsp.alarm;
		end
		check_value(16'({seen_ok, seen_alarm}), 16'({!s.alarm, s.alarm}),
			{tag, ", ok and alarm"});
		if (seen_ok && r.rd)
			check_value(rsp.dt, s.rdata, {tag, ", read data"});
		@(posedge clk);
		drive(s.port, '0);
		do begin
			@(negedge clk); // Ok must fall before the next cycle
			rsp = s.port ? rsp_chan : rsp_cpu;
		end while (rsp.ok);
	endtask

	initial begin
		int i;
		req_cpu = '0;
		req_chan = '0;
		rst = 1'b1;
		loaded = 1'b0;
		load_trace();
		if (steps.size() == 0) begin
			$display("The trace file holds no bus cycles");
			$display("tests failed");
			$fatal(1, "Empty trace");
		end else begin
			loaded = 1'b1;
			repeat (10) @(posedge clk);
			rst <= 1'b0;
			i = 0;
			while (i < steps.size()) begin
				if (steps[i].cmd == "P" && i + 1 < steps.size()) begin
					fork // Both ports start on the same edge
						run_cycle(steps[i], i);
						run_cycle(steps[i + 1], i + 1);
					join
					i += 2;
				end else begin
					run_cycle(steps[i], i);
					i += 1;
				end
			end
			repeat (2) @(posedge clk);
			$display("all tests passed");
			$finish;
		end
	end

	// Watchdog, scaled by the trace length
	initial begin
		longint limit;
		wait (loaded);
		limit = (longint'(steps.size()) * (`MEM_BUS_TIMEOUT + 10) + 20) * 8;
		#(limit);
		$display("Watchdog expired, the trace did not finish in time");
		$display("tests failed");
		$fatal(1, "Timeout");
	end

endmodule
